/* gb_cfg.svh */
/*
 * memory map and register constants for the console system core
 * bus widths, region codes, io register addresses, irq vectors
 */
`ifndef GB_CFG_SVH
`define GB_CFG_SVH

// ------------------------------
// bus widths
`define GB_ADDR_W        16
`define GB_DATA_W        8

// memory depths as address widths
`define GB_WRAM_AW       13        // 8k work ram
`define GB_ZP_AW         7         // 127 bytes used of 128

// ------------------------------
// address[15:13] region codes
`define GB_RGN_VRAM      3'b100    // 8000-9fff
`define GB_RGN_CRAM      3'b101    // a000-bfff, on the cartridge
`define GB_RGN_WRAM      3'b110    // c000-dfff
`define GB_RGN_ECHO      3'b111    // e000-fdff mirrors wram

// address[15:8] pages
`define GB_PAGE_BOOT     8'h00     // boot rom overlay
`define GB_PAGE_IO       8'hFF     // io regs + zero page

// single registers
`define GB_REG_JOY       16'hFF00
`define GB_REG_IF        16'hFF0F
`define GB_REG_BOOT      16'hFF50
`define GB_REG_IE        16'hFFFF

// ------------------------------
// interrupts
`define GB_NUM_IRQ       5
`define GB_IRQ_VEC_BASE  8'h40     // vblank
`define GB_IRQ_VEC_STEP  8'h08
`define GB_IRQ_VEC_NONE  8'h55     // nothing pending

`endif

/* gb_pkg.sv */
/*
 * gb_pkg
 * shared types of the system core: cpu bus bundle, the two
 * views of an address word, interrupt flag vector, decoder selects
 */
`default_nettype none

`include "gb_cfg.svh"

package gb_pkg;

	// one cycle of the external cpu bus
	typedef struct packed {
		logic [`GB_ADDR_W-1:0] addr;
		logic [`GB_DATA_W-1:0] dout;    // cpu write data
		logic                  rd;
		logic                  wr;
		logic                  ack;     // iorq + m1, irq acknowledge
	} cpu_bus_t;

	// io view, page + register
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] ioreg;
	} addr_io_t;

	// memory view, 8k region + 4k half + offset
	typedef struct packed {
		logic [2:0]  region;
		logic        bank_hi;
		logic [11:0] offset;
	} addr_mem_t;

	typedef union packed {
		addr_io_t  io;
		addr_mem_t mem;
	} gb_addr_u;

	// IF / IE layout, vblank in bit 0
	typedef struct packed {
		logic joypad;
		logic serial;
		logic timer;
		logic lcd;
		logic vblank;
	} irq_vec_t;

	// decoder output, at most one set
	typedef struct packed {
		logic rom;
		logic cram;
		logic vram;
		logic wram;     // includes echo
		logic zp;
		logic joy;
		logic if_r;
		logic ie_r;
		logic boot;
	} mem_sel_t;

endpackage

`default_nettype wire

/* gb_addr_decode.sv */
/*
 * cpu address decoder
 * turns the 16 bit cpu address into one-hot block selects,
 * memory regions from the top three bits, io from the page
 */
`timescale 1ns/10ps
`default_nettype none

`include "gb_cfg.svh"

module gb_addr_decode (
	input  gb_pkg::gb_addr_u addr,
	output gb_pkg::mem_sel_t sel
);

	logic io_page;      // ff00-ffff
	logic echo_top;     // fe00-ffff, oam and io, not echo
	logic zp_range;     // ff80-ffff before ie is removed

	assign io_page  = (addr.io.page == `GB_PAGE_IO);
	assign echo_top = addr.mem.bank_hi && (&addr.mem.offset[11:9]);
	assign zp_range = io_page && addr.io.ioreg[7];

	// ------------------------------
	// region and register decode
	always_comb begin
		sel = '0;

		// lower 32k is cartridge rom, boot rom overlaid outside
		sel.rom  = ~addr.mem.region[2];
		sel.vram = (addr.mem.region == `GB_RGN_VRAM);
		sel.cram = (addr.mem.region == `GB_RGN_CRAM);

		// c000-dfff plus e000-fdff mirror
		sel.wram = (addr.mem.region == `GB_RGN_WRAM) ||
			((addr.mem.region == `GB_RGN_ECHO) && !echo_top);

		sel.zp   = zp_range && (addr != `GB_REG_IE);    // ffff is ie

		sel.joy  = (addr == `GB_REG_JOY);
		sel.if_r = (addr == `GB_REG_IF);
		sel.ie_r = (addr == `GB_REG_IE);
		sel.boot = (addr == `GB_REG_BOOT);
	end

	// regions and registers must never overlap
	always_comb begin
		assert ($onehot0(sel))
		else $error("gb_addr_decode: more than one select for %h", addr);
	end

endmodule

`default_nettype wire

/* gb_irq_ctrl.sv */
/*
 * interrupt controller
 * IF / IE registers, edge capture of the event inputs, priority
 * vector for the ack cycle and clear of the served flag when ack ends
 */
`timescale 1ns/10ps
`default_nettype none

`include "gb_cfg.svh"

module gb_irq_ctrl (
	input  logic             clk_cpu,
	input  logic             reset_r,
	input  gb_pkg::cpu_bus_t bus,
	input  gb_pkg::mem_sel_t sel,
	input  logic             vblank_irq,
	input  logic             lcd_irq,
	input  logic             timer_irq,
	input  logic             serial_irq,
	input  logic [3:0]       joy_din,
	output gb_pkg::irq_vec_t if_q,
	output gb_pkg::irq_vec_t ie_q,
	output logic [7:0]       vec,
	output logic             irq_n
);

	logic [`GB_NUM_IRQ-1:0] if_r;
	logic [`GB_NUM_IRQ-1:0] ie_r;
	logic [`GB_NUM_IRQ-1:0] pend;       // enabled and flagged
	logic [`GB_NUM_IRQ-1:0] rise;       // new events this cycle
	logic [`GB_NUM_IRQ-1:0] clr;        // highest pending, one-hot
	logic [3:0]             ev_now;
	logic [3:0]             ev_q;       // last event levels
	logic [3:0]             joy_d1;
	logic [3:0]             joy_d2;
	logic                   joy_fall;
	logic                   ack_q;
	logic                   ack_end;
	logic                   if_wr;
	logic                   pend_any;
	logic [2:0]             pri_idx;

	assign ev_now   = {serial_irq, timer_irq, lcd_irq, vblank_irq};
	assign joy_fall = |(joy_d2 & ~joy_d1);          // any line P10..P13 went low
	assign rise     = {joy_fall, ev_now & ~ev_q};
	assign pend     = if_r & ie_r;
	assign ack_end  = ack_q && !bus.ack;
	assign if_wr    = sel.if_r && bus.wr;

	// ------------------------------
	// priority, bit 0 wins
	always_comb begin
		pri_idx  = '0;
		pend_any = 1'b0;
		for (int i = `GB_NUM_IRQ - 1; i >= 0; i--) begin
			if (pend[i]) begin
				pri_idx  = 3'(i);
				pend_any = 1'b1;
			end
		end
		clr          = '0;
		clr[pri_idx] = pend_any;
		vec = pend_any ? `GB_IRQ_VEC_BASE + `GB_IRQ_VEC_STEP * {5'd0, pri_idx}
			: `GB_IRQ_VEC_NONE;
	end

	// ------------------------------
	// flag and enable registers
	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			if_r   <= '0;
			ie_r   <= '0;
			ev_q   <= '0;
			joy_d1 <= '1;       // lines idle high
			joy_d2 <= '1;
			ack_q  <= 1'b0;
		end else begin
			ev_q   <= ev_now;
			joy_d1 <= joy_din;
			joy_d2 <= joy_d1;
			ack_q  <= bus.ack;

			if (if_wr)
				if_r <= bus.dout[`GB_NUM_IRQ-1:0];    // cpu write beats events
			else if (ack_end)
				if_r <= (if_r | rise) & ~clr;         // served flag drops
			else
				if_r <= if_r | rise;

			if (sel.ie_r && bus.wr)
				ie_r <= bus.dout[`GB_NUM_IRQ-1:0];
		end
	end

	assign if_q  = if_r;
	assign ie_q  = ie_r;
	assign irq_n = ~pend_any;

	// line low exactly when an enabled flag is set
	a_irq_vec: assert property (@(posedge clk_cpu) disable iff (reset_r)
		irq_n == ((if_r & ie_r) == '0));

	// end of ack removes the lowest pending flag
	a_ack_clr: assert property (@(posedge clk_cpu) disable iff (reset_r)
		($fell(bus.ack) && pend_any && !if_wr) |=>
			((if_r & $past(pend & (~pend + 1'b1))) == '0));

endmodule

`default_nettype wire

/* gb_ram.sv */
/*
 * internal work ram and zero page ram
 * 8k wram, echo at e000 folds onto it, 127 byte zero page,
 * both read through a register, one cycle latency
 */
`timescale 1ns/10ps
`default_nettype none

`include "gb_cfg.svh"

module gb_ram (
	input  logic                  clk_cpu,
	input  logic                  reset_r,
	input  gb_pkg::cpu_bus_t      bus,
	input  gb_pkg::mem_sel_t      sel,
	output logic [`GB_DATA_W-1:0] ram_do
);

	logic [`GB_DATA_W-1:0]  wram  [0:(1 << `GB_WRAM_AW) - 1];
	logic [`GB_DATA_W-1:0]  zpram [0:(1 << `GB_ZP_AW) - 1];

	gb_pkg::gb_addr_u       a;
	logic [`GB_WRAM_AW-1:0] wram_idx;
	logic [`GB_ZP_AW-1:0]   zp_idx;
	logic [`GB_DATA_W-1:0]  wram_q;
	logic [`GB_DATA_W-1:0]  zp_q;
	logic                   zp_last;    // zero page addressed last cycle

	assign a = bus.addr;

	// c000 and e000 share bits 12:0, so the echo needs no extra logic
	assign wram_idx = {a.mem.bank_hi, a.mem.offset};
	assign zp_idx   = a.io.ioreg[`GB_ZP_AW-1:0];   // ff80 -> 0

	// ------------------------------
	// work ram
	always_ff @(posedge clk_cpu) begin
		if (sel.wram && bus.wr)
			wram[wram_idx] <= bus.dout;
		wram_q <= wram[wram_idx];
	end

	// ------------------------------
	// zero page
	always_ff @(posedge clk_cpu) begin
		if (sel.zp && bus.wr)
			zpram[zp_idx] <= bus.dout;
		zp_q <= zpram[zp_idx];
	end

	// remember which array the data belongs to
	always_ff @(posedge clk_cpu) begin
		if (reset_r)
			zp_last <= 1'b0;
		else
			zp_last <= sel.zp;
	end

	assign ram_do = zp_last ? zp_q : wram_q;

endmodule

`default_nettype wire

/* gb_sys_regs.sv */
/*
 * system control registers
 * joypad select P54 at ff00 and the boot rom enable flag at ff50
 */
`timescale 1ns/10ps
`default_nettype none

`include "gb_cfg.svh"

module gb_sys_regs (
	input  logic                  clk_cpu,
	input  logic                  reset_r,
	input  gb_pkg::cpu_bus_t      bus,
	input  gb_pkg::mem_sel_t      sel,
	input  logic [3:0]            joy_din,
	output logic [`GB_DATA_W-1:0] joy_do,
	output logic [1:0]            p54,
	output logic                  boot_en
);

	// ------------------------------
	// joypad row select
	always_ff @(posedge clk_cpu) begin
		if (reset_r)
			p54 <= 2'b11;               // no row selected
		else if (sel.joy && bus.wr)
			p54 <= bus.dout[5:4];
	end

	// P1 readback, top bits unused and read as 1
	assign joy_do = {2'b11, p54, joy_din};

	// ------------------------------
	// boot rom overlay, one way switch
	always_ff @(posedge clk_cpu) begin
		if (reset_r)
			boot_en <= 1'b1;
		else if (sel.boot && bus.wr && bus.dout[0])
			boot_en <= 1'b0;            // only reset brings it back
	end

endmodule

`default_nettype wire

/* gb_bus_core.sv */
/*
 * system core top level
 * address decode, internal rams, interrupt controller and system
 * registers, cpu read data mux and cartridge strobes
 */
`timescale 1ns/10ps
`default_nettype none

`include "gb_cfg.svh"

module gb_bus_core (
	input  logic                  clk_cpu,
	input  logic                  reset_r,
	input  gb_pkg::cpu_bus_t      bus,
	input  logic                  vblank_irq,
	input  logic                  lcd_irq,
	input  logic                  timer_irq,
	input  logic                  serial_irq,
	input  logic [3:0]            joy_din,
	input  logic [`GB_DATA_W-1:0] cart_do,
	input  logic [`GB_DATA_W-1:0] boot_do,
	output logic [`GB_DATA_W-1:0] cpu_din,
	output logic                  irq_n,
	output logic [1:0]            p54,
	output logic [`GB_ADDR_W-1:0] cart_addr,
	output logic                  cart_rd,
	output logic                  cart_wr
);

	gb_pkg::gb_addr_u      addr_u;
	gb_pkg::mem_sel_t      sel;
	gb_pkg::irq_vec_t      if_q;
	gb_pkg::irq_vec_t      ie_q;
	logic [7:0]            vec;
	logic [`GB_DATA_W-1:0] ram_do;
	logic [`GB_DATA_W-1:0] joy_do;
	logic [`GB_DATA_W-1:0] rom_do;
	logic                  boot_en;

	assign addr_u = bus.addr;

	gb_addr_decode u_dec (
		.addr (addr_u),
		.sel  (sel)
	);

	gb_ram u_ram (
		.clk_cpu (clk_cpu),
		.reset_r (reset_r),
		.bus     (bus),
		.sel     (sel),
		.ram_do  (ram_do)
	);

	gb_irq_ctrl u_irq (
		.clk_cpu    (clk_cpu),
		.reset_r    (reset_r),
		.bus        (bus),
		.sel        (sel),
		.vblank_irq (vblank_irq),
		.lcd_irq    (lcd_irq),
		.timer_irq  (timer_irq),
		.serial_irq (serial_irq),
		.joy_din    (joy_din),
		.if_q       (if_q),
		.ie_q       (ie_q),
		.vec        (vec),
		.irq_n      (irq_n)
	);

	gb_sys_regs u_sys (
		.clk_cpu (clk_cpu),
		.reset_r (reset_r),
		.bus     (bus),
		.sel     (sel),
		.joy_din (joy_din),
		.joy_do  (joy_do),
		.p54     (p54),
		.boot_en (boot_en)
	);

	// ------------------------------
	// read data, first match wins
	assign rom_do = (boot_en && addr_u.io.page == `GB_PAGE_BOOT) ? boot_do : cart_do;

	always_comb begin
		if (bus.ack)
			cpu_din = vec;                  // rst vector during ack
		else if (sel.if_r)
			cpu_din = {3'b111, if_q};
		else if (sel.joy)
			cpu_din = joy_do;
		else if (sel.rom)
			cpu_din = rom_do;
		else if (sel.cram)
			cpu_din = cart_do;
		else if (sel.zp || sel.wram)
			cpu_din = ram_do;               // registered, addr held 2 cycles
		else if (sel.ie_r)
			cpu_din = {3'b000, ie_q};
		else
			cpu_din = 8'hFF;                // open bus
	end

	// ------------------------------
	// cartridge side
	assign cart_addr = bus.addr;
	assign cart_rd   = (sel.rom || sel.cram) && bus.rd;
	assign cart_wr   = (sel.rom || sel.cram) && bus.wr;    // mbc writes go to rom space

endmodule

`default_nettype wire

/* tb_gb_bus_core.sv */
/*
 * testbench for the system core
 * a table of bus operations with expected results, applied in order,
 * covering reset state, rams, interrupts, joypad and boot overlay
 */
`timescale 1ns/10ps
`default_nettype none

`include "gb_cfg.svh"

module tb_gb_bus_core;

	// ------------------------------
	// table operations
	localparam logic [3:0] OP_WR    = 4'd0;    // write data to addr
	localparam logic [3:0] OP_RD    = 4'd1;    // read addr, compare cpu_din
	localparam logic [3:0] OP_CRD   = 4'd2;    // read addr, compare cart_rd
	localparam logic [3:0] OP_PULSE = 4'd3;    // data[3:0] = serial,timer,lcd,vblank
	localparam logic [3:0] OP_ACK   = 4'd4;    // ack cycle, compare vector
	localparam logic [3:0] OP_IRQN  = 4'd5;    // compare irq_n
	localparam logic [3:0] OP_JOY   = 4'd6;    // new joy_din level
	localparam logic [3:0] OP_POLL  = 4'd7;    // read until match, data = max cycles
	localparam logic [3:0] OP_P54   = 4'd8;    // compare p54 port
	localparam logic [3:0] OP_CWR   = 4'd9;    // write addr, compare cart_wr

	localparam logic [7:0] CART_BYTE = 8'h3C;
	localparam logic [7:0] BOOT_BYTE = 8'hA5;

	typedef struct packed {
		logic [3:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  expected;
	} step_t;

	logic             clk_cpu;
	logic             reset_r;
	gb_pkg::cpu_bus_t bus;
	logic             vblank_irq;
	logic             lcd_irq;
	logic             timer_irq;
	logic             serial_irq;
	logic [3:0]       joy_din;
	logic [7:0]       cart_do;
	logic [7:0]       boot_do;
	logic [7:0]       cpu_din;
	logic             irq_n;
	logic [1:0]       p54;
	logic [15:0]      cart_addr;
	logic             cart_rd;
	logic             cart_wr;

	step_t steps [$];
	int    n_checks      = 0;
	int    n_errors      = 0;
	int    cycle_cnt     = 0;
	int    timeout_limit = 2000;     // resized once the table is built
	int    seed_val;

	gb_bus_core dut (
		.clk_cpu    (clk_cpu),
		.reset_r    (reset_r),
		.bus        (bus),
		.vblank_irq (vblank_irq),
		.lcd_irq    (lcd_irq),
		.timer_irq  (timer_irq),
		.serial_irq (serial_irq),
		.joy_din    (joy_din),
		.cart_do    (cart_do),
		.boot_do    (boot_do),
		.cpu_din    (cpu_din),
		.irq_n      (irq_n),
		.p54        (p54),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr)
	);

	// 100 ns clock
	initial begin
		clk_cpu = 1'b0;
		forever #50 clk_cpu = ~clk_cpu;
	end

	// run limit
	always @(posedge clk_cpu) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > timeout_limit) begin
			$display("timeout: table not finished after %0d cycles", timeout_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ------------------------------
	// helpers
	task automatic add_step(input logic [3:0] op, input logic [15:0] addr,
		input logic [7:0] data, input logic [7:0] expected);
		steps.push_back('{op, addr, data, expected});
	endtask

	task automatic bus_idle();
		bus.addr = 16'h0000;
		bus.dout = 8'h00;
		bus.rd   = 1'b0;
		bus.wr   = 1'b0;
		bus.ack  = 1'b0;
	endtask

	// one rising edge, back on the falling edge
	task automatic next_cycle();
		@(posedge clk_cpu);
		@(negedge clk_cpu);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
		input logic [7:0] exp, input int idx);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("CHECK FAILED step %0d: %s = %h, expected %h", idx, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] got,
		input logic [15:0] exp, input int idx);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("CHECK FAILED step %0d: %s = %h, expected %h", idx, name, got, exp);
		end
	endtask

	task automatic run_step(input step_t s, input int idx);
		int   waited;
		logic hit;
		waited = 0;
		hit    = 1'b0;
		case (s.op)
			OP_WR: begin
				bus.addr = s.addr;
				bus.dout = s.data;
				bus.wr   = 1'b1;
				next_cycle();
				bus_idle();
			end
			OP_RD: begin
				bus.addr = s.addr;
				bus.rd   = 1'b1;
				next_cycle();                   // covers the ram latency
				check_byte("cpu_din", cpu_din, s.expected, idx);
				bus_idle();
			end
			OP_CRD: begin
				bus.addr = s.addr;
				bus.rd   = 1'b1;
				next_cycle();
				check_byte("cart_rd", {7'd0, cart_rd}, s.expected, idx);
				check_word("cart_addr", cart_addr, s.addr, idx);    // straight through
				bus_idle();
			end
			OP_CWR: begin
				bus.addr = s.addr;
				bus.dout = s.data;
				bus.wr   = 1'b1;
				next_cycle();
				check_byte("cart_wr", {7'd0, cart_wr}, s.expected, idx);
				bus_idle();
			end
			OP_PULSE: begin
				{serial_irq, timer_irq, lcd_irq, vblank_irq} = s.data[3:0];
				next_cycle();
				{serial_irq, timer_irq, lcd_irq, vblank_irq} = 4'h0;
			end
			OP_ACK: begin
				bus.ack = 1'b1;
				next_cycle();
				check_byte("cpu_din", cpu_din, s.expected, idx);
				bus.ack = 1'b0;
				next_cycle();                   // flag clears here
			end
			OP_IRQN: begin
				next_cycle();
				check_byte("irq_n", {7'd0, irq_n}, s.expected, idx);
			end
			OP_JOY: begin
				joy_din = s.data[3:0];
				next_cycle();
			end
			OP_POLL: begin
				bus.addr = s.addr;
				bus.rd   = 1'b1;
				while (!hit && waited < int'(s.data)) begin
					next_cycle();
					waited++;
					hit = (cpu_din === s.expected);
				end
				n_checks++;
				if (!hit) begin
					n_errors++;
					$display("CHECK FAILED step %0d: cpu_din = %h, expected %h within %0d cycles",
						idx, cpu_din, s.expected, s.data);
				end
				bus_idle();
			end
			OP_P54: begin
				next_cycle();
				check_byte("p54", {6'd0, p54}, s.expected, idx);
			end
			default: begin
				n_errors++;
				$display("step %0d has an unknown operation code %0d", idx, s.op);
			end
		endcase
	endtask

	// ------------------------------
	// stimulus table
	task automatic build_steps();
		logic [7:0]  rnd;
		logic [15:0] off;
		// reset state
		add_step(OP_RD,   `GB_REG_IF,  8'h00, 8'hE0);    // unused bits read 1
		add_step(OP_RD,   `GB_REG_IE,  8'h00, 8'h00);
		add_step(OP_RD,   `GB_REG_JOY, 8'h00, 8'hF0 | 8'h0F);
		add_step(OP_IRQN, 16'h0000,    8'h00, 8'h01);
		add_step(OP_P54,  16'h0000,    8'h00, 8'h03);
		// wram through c000 and the echo
		for (int n = 0; n < 4; n++) begin
			rnd = 8'($urandom);
			off = 16'(n * 16'h0531);
			add_step(OP_WR, 16'hC000 + off, rnd, 8'h00);
			add_step(OP_RD, 16'hE000 + off, 8'h00, rnd);
			add_step(OP_RD, 16'hC000 + off, 8'h00, rnd);
		end
		add_step(OP_WR, 16'hDFFF, 8'h5A, 8'h00);          // top of wram
		add_step(OP_RD, 16'hDFFF, 8'h00, 8'h5A);
		// zero page, kept apart from wram
		add_step(OP_WR, 16'hFF80, 8'h11, 8'h00);
		add_step(OP_WR, 16'hFFFE, 8'hEE, 8'h00);
		add_step(OP_WR, 16'hC07E, 8'h77, 8'h00);          // same low bits as fffe
		add_step(OP_RD, 16'hFF80, 8'h00, 8'h11);
		add_step(OP_RD, 16'hFFFE, 8'h00, 8'hEE);
		// interrupts, vblank and timer together
		add_step(OP_WR,    `GB_REG_IE, 8'h1F, 8'h00);
		add_step(OP_PULSE, 16'h0000,   8'h05, 8'h00);
		add_step(OP_RD,    `GB_REG_IF, 8'h00, 8'hE5);
		add_step(OP_IRQN,  16'h0000,   8'h00, 8'h00);
		add_step(OP_ACK,   16'h0000,   8'h00, `GB_IRQ_VEC_BASE);
		add_step(OP_RD,    `GB_REG_IF, 8'h00, 8'hE4);    // only timer left
		add_step(OP_ACK,   16'h0000,   8'h00, `GB_IRQ_VEC_BASE + 2 * `GB_IRQ_VEC_STEP);
		add_step(OP_RD,    `GB_REG_IF, 8'h00, 8'hE0);
		add_step(OP_IRQN,  16'h0000,   8'h00, 8'h01);
		add_step(OP_PULSE, 16'h0000,   8'h08, 8'h00);    // serial
		add_step(OP_IRQN,  16'h0000,   8'h00, 8'h00);
		add_step(OP_WR,    `GB_REG_IF, 8'h00, 8'h00);
		add_step(OP_IRQN,  16'h0000,   8'h00, 8'h01);
		add_step(OP_RD,    `GB_REG_IE, 8'h00, 8'h1F);
		// joypad, P10 falls
		add_step(OP_JOY,  16'h0000,    8'h0E, 8'h00);
		add_step(OP_POLL, `GB_REG_IF,  8'h04, 8'hF0);
		add_step(OP_IRQN, 16'h0000,    8'h00, 8'h00);
		add_step(OP_RD,   `GB_REG_JOY, 8'h00, 8'hFE);
		add_step(OP_JOY,  16'h0000,    8'h0F, 8'h00);
		add_step(OP_WR,   `GB_REG_IF,  8'h00, 8'h00);
		add_step(OP_WR,   `GB_REG_JOY, 8'h10, 8'h00);
		add_step(OP_P54,  16'h0000,    8'h00, 8'h01);
		add_step(OP_RD,   `GB_REG_JOY, 8'h00, 8'hDF);
		// boot overlay and cartridge strobes
		add_step(OP_RD,  16'h0042,     8'h00, BOOT_BYTE);
		add_step(OP_RD,  16'h0142,     8'h00, CART_BYTE);
		add_step(OP_WR,  `GB_REG_BOOT, 8'h01, 8'h00);
		add_step(OP_RD,  16'h0042,     8'h00, CART_BYTE);
		add_step(OP_RD,  16'hA010,     8'h00, CART_BYTE);
		add_step(OP_RD,  16'hFF7F,     8'h00, 8'hFF);    // unmapped
		add_step(OP_CRD, 16'h0042,     8'h00, 8'h01);
		add_step(OP_CRD, 16'hA010,     8'h00, 8'h01);
		add_step(OP_CRD, 16'hC010,     8'h00, 8'h00);
		add_step(OP_CRD, 16'hFF80,     8'h00, 8'h00);
		add_step(OP_CWR, 16'h2000,     8'h01, 8'h01);    // mbc bank select
		add_step(OP_CWR, 16'hA010,     8'h99, 8'h01);
		add_step(OP_CWR, 16'hC010,     8'h99, 8'h00);
		add_step(OP_CWR, 16'hFF7F,     8'h99, 8'h00);
	endtask

	// ------------------------------
	// main sequence
	initial begin
		seed_val = $urandom(19276);
		reset_r  = 1'b1;
		bus_idle();
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
		serial_irq = 1'b0;
		joy_din    = 4'hF;                     // no key pressed
		cart_do    = CART_BYTE;
		boot_do    = BOOT_BYTE;
		build_steps();
		timeout_limit = steps.size() * 4 + 8 + 50;
		repeat (8) @(posedge clk_cpu);
		@(negedge clk_cpu);
		reset_r = 1'b0;
		foreach (steps[i])
			run_step(steps[i], i);
		$display("checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
gb_pkg.sv
gb_addr_decode.sv
gb_irq_ctrl.sv
gb_ram.sv
gb_sys_regs.sv
gb_bus_core.sv
tb_gb_bus_core.sv

/* Makefile */
# Verilator build and run for the system core testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_gb_bus_core
RTL_TOP   ?= gb_bus_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LFLAGS    ?= --lint-only --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG) || ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
